// File: logic/fcs_defines.svh
`ifndef FCS_DEFINES_SVH
`define FCS_DEFINES_SVH

// Number of checking lanes working side by side.
`define FCS_LANES 4

// CRC-32 generator polynomial, normal (non-reflected) form.
`define FCS_POLY 32'h04C11DB7

// Width of the frame byte counter, enough for 2047 byte frames.
`define FCS_LEN_W 11

`endif

// File: logic/fcs_pkg.sv
`include "fcs_defines.svh"

package fcs_pkg;

  // ======================================================================
  // Stream and result records
  // ======================================================================

  // One received byte of a frame.
  typedef struct packed {
    logic [7:0] data;   // Byte value, sent MSB first on the line.
    logic       last;   // Set on the final FCS byte of the frame.
  } byte_beat_t;

  // Outcome of one checked frame.
  typedef struct packed {
    logic [31:0]           crc;   // Inverted remainder over the payload.
    logic                  good;  // Set when crc matches the received FCS.
    logic [`FCS_LEN_W-1:0] len;   // Frame length in bytes, FCS included.
  } fcs_result_t;

endpackage

// File: logic/frame_dispatch.sv
`timescale 1ns/1ps
`include "fcs_defines.svh"

module frame_dispatch (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fcs_pkg::byte_beat_t   in_beat,
  output logic [`FCS_LANES-1:0] lane_in_valid,
  input  logic [`FCS_LANES-1:0] lane_in_ready,
  output fcs_pkg::byte_beat_t   lane_in_beat
);

  localparam int TURN_W = (`FCS_LANES > 1) ? $clog2(`FCS_LANES) : 1;

  logic [TURN_W-1:0] turn;       // Lane that receives the current frame.
  logic              take_last;

  // ======================================================================
  // Handshake steering
  // ======================================================================

  // The ready of the selected lane goes straight back to the source.
  assign in_ready = lane_in_ready[turn];

  // Every lane sees the same beat. Only the selected one gets a valid.
  assign lane_in_beat = in_beat;

  always_comb
  begin
    lane_in_valid       = '0;
    lane_in_valid[turn] = in_valid;
  end

  // The frame ends here when its closing byte is taken.
  assign take_last = in_valid && in_ready && in_beat.last;

  // ======================================================================
  // Round-robin turn pointer
  // ======================================================================

  always_ff @(posedge CLK)
  begin
    if (!RST)
      turn <= '0;
    else if (take_last)
    begin
      if (turn == TURN_W'(`FCS_LANES - 1))
        turn <= '0;                     // Wrap back to lane 0.
      else
        turn <= turn + 1'b1;
    end
  end

endmodule

// File: logic/fcs_lane.sv
`timescale 1ns/1ps
`include "fcs_defines.svh"

module fcs_lane (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fcs_pkg::byte_beat_t  in_beat,
  output logic                 res_valid,
  input  logic                 res_ready,
  output fcs_pkg::fcs_result_t res
);

  typedef enum logic [2:0] {
    ST_RST,    // First cycle after reset.
    ST_LOAD,   // Waiting for a beat.
    ST_SHIFT,  // Byte leaves the shift register one bit per clock.
    ST_FLUSH,  // Augmentation bits through the engine.
    ST_CMP,    // Remainder against the held-back FCS.
    ST_RES     // Result waits for the collector.
  } lane_state_t;

  lane_state_t           state;
  logic [7:0]            sreg;       // Byte being serialized.
  logic [2:0]            bit_cnt;    // Bits left in sreg, minus one.
  logic                  last_q;
  logic [31:0]           dbuf;       // Holds the newest 32 frame bits.
  logic [5:0]            fill_cnt;   // Saturates at 32.
  logic [5:0]            pre_cnt;    // Engine inputs so far, saturates at 32.
  logic [31:0]           crc;
  logic [5:0]            flush_cnt;
  logic [`FCS_LEN_W-1:0] len_cnt;
  logic                  pre_bit;

  // One step of the serial divider with polynomial feedback.
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    logic [31:0] fb;
    fb = c[31] ? `FCS_POLY : 32'h0;
    return {c[30:0], b} ^ fb;
  endfunction

  assign in_ready  = (state == ST_LOAD);
  assign res_valid = (state == ST_RES);

  // High while the engine is still inside the 32-bit preset window.
  assign pre_bit = ~pre_cnt[5];

  // ======================================================================
  // Control and CRC engine
  // ======================================================================

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= ST_RST;
      bit_cnt   <= '0;
      last_q    <= 1'b0;
      fill_cnt  <= '0;
      pre_cnt   <= '0;
      crc       <= '0;
      flush_cnt <= '0;
      len_cnt   <= '0;
    end
    else
    begin
      case (state)
        ST_RST:
          state <= ST_LOAD;
        ST_LOAD:
          if (in_valid)
          begin
            state   <= ST_SHIFT;
            bit_cnt <= 3'd7;
            last_q  <= in_beat.last;
            len_cnt <= len_cnt + 1'b1;
          end
        ST_SHIFT:
        begin
          // Once the buffer is full its oldest bit enters the engine.
          if (fill_cnt[5])
          begin
            crc <= crc_step(crc, dbuf[31]);
            if (!pre_cnt[5])
              pre_cnt <= pre_cnt + 1'b1;
          end
          else
            fill_cnt <= fill_cnt + 1'b1;
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == 3'd0)
          begin
            if (last_q)
            begin
              state     <= ST_FLUSH;
              flush_cnt <= 6'd32;
            end
            else
              state <= ST_LOAD;
          end
        end
        ST_FLUSH:
        begin
          // Short payloads still owe part of the preset, so those zeros go in inverted.
          crc <= crc_step(crc, pre_bit);
          if (!pre_cnt[5])
            pre_cnt <= pre_cnt + 1'b1;
          flush_cnt <= flush_cnt - 1'b1;
          if (flush_cnt == 6'd1)
            state <= ST_CMP;
        end
        ST_CMP:
        begin
          state    <= ST_RES;       // Counters start over for the next frame.
          fill_cnt <= '0;
          pre_cnt  <= '0;
          crc      <= '0;
          len_cnt  <= '0;
        end
        ST_RES:
          if (res_ready)
            state <= ST_LOAD;
        default:
          state <= ST_RST;
      endcase
    end
  end

  // ======================================================================
  // Shift register, delay buffer and result
  // ======================================================================

  always_ff @(posedge CLK)
  begin
    case (state)
      ST_LOAD:
        if (in_valid)
          sreg <= in_beat.data;
      ST_SHIFT:
      begin
        sreg <= {sreg[6:0], 1'b0};
        dbuf <= {dbuf[30:0], sreg[7] ^ ~fill_cnt[5]}; // First 32 bits inverted.
      end
      ST_FLUSH:
        // A full turn of the buffer, undoing the inversion on FCS bits inside the preset window.
        dbuf <= {dbuf[30:0], dbuf[31] ^ pre_bit};
      ST_CMP:
      begin
        res.crc  <= ~crc;
        res.good <= (~crc == dbuf);
        res.len  <= len_cnt;
      end
      default:
        sreg <= sreg;
    endcase
  end

endmodule

// File: logic/result_collect.sv
`timescale 1ns/1ps
`include "fcs_defines.svh"

module result_collect (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic [`FCS_LANES-1:0]                  lane_res_valid,
  output logic [`FCS_LANES-1:0]                  lane_res_ready,
  input  fcs_pkg::fcs_result_t [`FCS_LANES-1:0]  lane_res,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output fcs_pkg::fcs_result_t                   out_result
);

  localparam int TURN_W = (`FCS_LANES > 1) ? $clog2(`FCS_LANES) : 1;

  logic [TURN_W-1:0] turn;   // Lane whose result leaves next.
  logic              take;

  // Only the lane in turn is visible, so frame order is kept
  // even when a later lane finishes first.
  assign out_valid  = lane_res_valid[turn];
  assign out_result = lane_res[turn];
  assign take       = out_valid && out_ready;

  always_comb
  begin
    lane_res_ready       = '0;
    lane_res_ready[turn] = out_ready;   // Back-pressure reaches that lane only.
  end

  // ======================================================================
  // Turn pointer, same sequence as the dispatcher
  // ======================================================================

  always_ff @(posedge CLK)
  begin
    if (!RST)
      turn <= '0;
    else if (take)
    begin
      if (turn == TURN_W'(`FCS_LANES - 1))
        turn <= '0;
      else
        turn <= turn + 1'b1;
    end
  end

endmodule

// File: logic/fcs_check_top.sv
`timescale 1ns/1ps
`include "fcs_defines.svh"

module fcs_check_top (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fcs_pkg::byte_beat_t  in_beat,
  output logic                 out_valid,
  input  logic                 out_ready,
  output fcs_pkg::fcs_result_t out_result
);

  import fcs_pkg::*;

  logic [`FCS_LANES-1:0]        lane_in_valid;
  logic [`FCS_LANES-1:0]        lane_in_ready;
  byte_beat_t                   lane_in_beat;     // Shared by all lanes.
  logic [`FCS_LANES-1:0]        lane_res_valid;
  logic [`FCS_LANES-1:0]        lane_res_ready;
  fcs_result_t [`FCS_LANES-1:0] lane_res;

  frame_dispatch u_dispatch (
    .CLK           (CLK),
    .RST           (RST),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_beat       (in_beat),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready),
    .lane_in_beat  (lane_in_beat)
  );

  // Whole frames go to the lanes in turn, so several are checked at once.
  for (genvar i = 0; i < `FCS_LANES; i++)
  begin : g_lane
    fcs_lane u_lane (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (lane_in_valid[i]),
      .in_ready  (lane_in_ready[i]),
      .in_beat   (lane_in_beat),
      .res_valid (lane_res_valid[i]),
      .res_ready (lane_res_ready[i]),
      .res       (lane_res[i])
    );
  end

  result_collect u_collect (
    .CLK            (CLK),
    .RST            (RST),
    .lane_res_valid (lane_res_valid),
    .lane_res_ready (lane_res_ready),
    .lane_res       (lane_res),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_result     (out_result)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;   // 20 ns period.
  end

  initial
  begin
    RST = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;   // Released half a cycle away from the sampling edge.
  end

endmodule

// File: sim/fcs_properties.sv
`timescale 1ns/1ps

module fcs_properties (
  input logic                 CLK,
  input logic                 RST,
  input logic                 in_valid,
  input logic                 in_ready,
  input fcs_pkg::byte_beat_t  in_beat,
  input logic                 out_valid,
  input logic                 out_ready,
  input fcs_pkg::fcs_result_t out_result
);

  int fail_count = 0;

  // An offered beat stays put until the dispatcher takes it.
  a_in_hold : assert property (@(posedge CLK) disable iff (!RST)
    in_valid && !in_ready |=> in_valid && $stable(in_beat))
  else
  begin
    fail_count++;
    $error("Input beat changed or was withdrawn before it was taken");
  end

  // A stalled result keeps its valid and its value.
  a_out_hold : assert property (@(posedge CLK) disable iff (!RST)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
  else
  begin
    fail_count++;
    $error("Stalled result changed or was withdrawn");
  end

  // Once reset has been seen for a cycle both handshakes are quiet.
  a_reset_quiet : assert property (@(posedge CLK)
    !RST && $past(!RST) |-> !in_ready && !out_valid)
  else
  begin
    fail_count++;
    $error("in_ready or out_valid high while reset is held");
  end

endmodule

// File: sim/fcs_scoreboard.sv
`timescale 1ns/1ps

module fcs_scoreboard (
  input logic                 CLK,
  input logic                 RST,
  input logic                 in_ready,
  input logic                 out_valid,
  input logic                 out_ready,
  input fcs_pkg::fcs_result_t out_result
);

  import fcs_pkg::*;

  string       exp_names[$];     // Frame names in file order.
  fcs_result_t exp_results[$];
  int          seen = 0;
  int          errors = 0;

  task automatic push_expect(input string name, input fcs_result_t r);
    exp_names.push_back(name);
    exp_results.push_back(r);
  endtask

  task automatic check_result(input fcs_result_t act);
    string       name;
    fcs_result_t exp;
    if (exp_results.size() == 0)
    begin
      $display("Extra result with crc %h arrived after every frame was checked", act.crc);
      errors++;
    end
    else
    begin
      name = exp_names.pop_front();
      exp  = exp_results.pop_front();
      if (act.crc !== exp.crc)
      begin
        $display("MISMATCH %s crc expected %h actual %h", name, exp.crc, act.crc);
        errors++;
      end
      if (act.good !== exp.good)
      begin
        $display("MISMATCH %s good expected %b actual %b", name, exp.good, act.good);
        errors++;
      end
      if (act.len !== exp.len)
      begin
        $display("MISMATCH %s len expected %0d actual %0d", name, exp.len, act.len);
        errors++;
      end
    end
  endtask

  // Results are compared on the edge where the transfer happens.
  always @(posedge CLK)
  begin
    if (!RST && (in_ready || out_valid))
    begin
      $display("Handshake active during reset, in_ready %b out_valid %b", in_ready, out_valid);
      errors++;
    end
    else if (RST && out_valid && out_ready)
    begin
      seen++;
      check_result(out_result);
    end
  end

  task automatic close_report(input int assert_fails, output int total);
    int missing;
    missing = exp_results.size();
    while (exp_names.size() > 0)
      $display("No result arrived for frame %s", exp_names.pop_front());
    total = errors + missing + assert_fails;
    $display("Checked %0d results, %0d errors, %0d missing, %0d assertion failures",
             seen, errors, missing, assert_fails);
  endtask

endmodule

// File: sim/fcs_tb.sv
`timescale 1ns/1ps
`include "fcs_defines.svh"

module fcs_tb;

  import fcs_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h9f14_2214;

  logic        CLK;
  logic        RST;
  logic        in_valid;
  logic        in_ready;
  byte_beat_t  in_beat;
  logic        out_valid;
  logic        out_ready;
  fcs_result_t out_result;

  logic [31:0] lfsr;
  logic [7:0]  frame_bytes[$];   // Bytes of all frames back to back with each FCS included.
  logic        last_flags[$];
  int          n_tests = 0;
  int          limit_cycles = 0;

  tb_clock clk_i (.CLK(CLK), .RST(RST));

  fcs_check_top dut_i (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  fcs_scoreboard sb_i (
    .CLK        (CLK),
    .RST        (RST),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  bind fcs_check_top fcs_properties props_i (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  // ====================================================================
  // Random source and test file
  // ====================================================================

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};   // One step per bit taken.
    end
  endtask

  task automatic load_tests(output bit ok);
    int          fd;
    int          n;
    string       tok;
    string       rest;
    int          len;
    logic [31:0] crc;
    int          good;
    logic [7:0]  b;
    fcs_result_t r;
    ok = 1'b0;
    fd = $fopen("sim/fcs_tests.txt", "r");
    if (fd == 0)
      return;
    while ($fscanf(fd, "%s", tok) == 1)
    begin
      if (tok.getc(0) == "#")
        n = $fgets(rest, fd);
      else
      begin
        n = $fscanf(fd, "%d %h %d", len, crc, good);
        for (int i = 0; i < len; i++)
        begin
          n = $fscanf(fd, "%h", b);
          frame_bytes.push_back(b);
          last_flags.push_back(i == len - 1);
        end
        r.crc  = crc;
        r.good = good[0];
        r.len  = len[`FCS_LEN_W-1:0];
        sb_i.push_expect(tok, r);
        limit_cycles += 60 * len + 200;
        n_tests++;
      end
    end
    $fclose(fd);
    ok = (n_tests > 0);
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial
  begin
    logic [7:0] r;
    bit         ok;
    bit         sent;
    bit         hold_out;
    int         blocked;
    int         pos;
    int         total_errors;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    lfsr      = LFSR_SEED;
    sent      = 1'b0;
    hold_out  = 1'b1;   // Results are held at first so that every lane fills up.
    blocked   = 0;
    pos       = 0;
    load_tests(ok);
    if (!ok)
    begin
      $display("Could not read any test from sim/fcs_tests.txt");
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      wait (RST);
      while (pos < frame_bytes.size() || sb_i.seen < n_tests)
      begin
        @(negedge CLK);
        if (sent)
          in_valid = 1'b0;
        // A held phase ends once the input has been refused long enough
        // for every lane to hold a frame, or when no input is left.
        if (blocked >= 16 || pos >= frame_bytes.size())
          hold_out = 1'b0;
        else if (!hold_out)
        begin
          draw_bits(5, r);
          hold_out = (r[4:0] == 5'b00000);
        end
        draw_bits(2, r);
        out_ready = !hold_out && (r[1:0] != 2'b00);   // Low about a quarter of the time.
        if (!in_valid && pos < frame_bytes.size())
        begin
          draw_bits(3, r);
          if (r[2:0] != 3'b000)          // Rare gaps keep several frames in flight.
          begin
            in_valid     = 1'b1;
            in_beat.data = frame_bytes[pos];
            in_beat.last = last_flags[pos];
          end
        end
        sent = in_valid && in_ready;     // in_ready holds until the next rising edge.
        if (in_valid && !in_ready)
          blocked++;
        else
          blocked = 0;
        @(posedge CLK);
        if (sent)
          pos++;
      end
      @(negedge CLK);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      repeat (20 * `FCS_LANES) @(posedge CLK);   // A repeated result would show up here.
      sb_i.close_report(dut_i.props_i.fail_count, total_errors);
      if (total_errors == 0)
        $display("TEST OK");
      else
        $display("TEST FAILED");
      $finish;
    end
  end

  // The watchdog limit is sized from the frame lengths read from the file.
  initial
  begin
    wait (RST);
    repeat (limit_cycles + 100 * `FCS_LANES) @(posedge CLK);
    $display("Timeout, only %0d of %0d results arrived", sb_i.seen, n_tests);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+logic
logic/fcs_pkg.sv
logic/frame_dispatch.sv
logic/fcs_lane.sv
logic/result_collect.sv
logic/fcs_check_top.sv
sim/tb_clock.sv
sim/fcs_properties.sv
sim/fcs_scoreboard.sv
sim/fcs_tb.sv

// File: Makefile
TOP := fcs_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into sim.log, look for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "TEST OK" sim.log || (echo "Simulation did not pass, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: sim/fcs_tests.txt
# name  length  expected_crc  expected_good  frame bytes in hex, FCS last
# Frame bytes may wrap over several lines.
check_str   13 FC891918 1 31 32 33 34 35 36 37 38 39 FC 89 19 18
min_ff       5 000000FF 1 FF 00 00 00 FF
long_frame 200 38FB2284 1
00 00 00 00 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84 38 FB 22 84
38 FB 22 84 38 FB 22 84
min_fe       5 04C11D48 1 FE 04 C1 1D 48
zero_word    8 38FB2284 1 00 00 00 00 38 FB 22 84
bad_payload 13 F84804AF 0 31 32 33 34 35 36 37 38 38 FC 89 19 18
two_ff       6 0000FFFF 1 FF FF 00 00 FF FF
after_word   9 FB2284FF 1 00 00 00 00 C7 FB 22 84 FF
bad_fcs     13 FC891918 0 31 32 33 34 35 36 37 38 39 FC 89 19 19
min_bad      5 04C11D48 0 FE 04 C1 1D 49
